// File: verilog/rename_pkg.sv
`default_nettype none

package rename_pkg;

    localparam int NUM_ARCH   = 32;
    localparam int LOG_ARCH   = 5;
    localparam int NUM_PHYS   = 64;
    localparam int LOG_PHYS   = 6;
    localparam int FREE_DEPTH = NUM_PHYS - NUM_ARCH;   // renamable registers
    localparam int LOG_FREE   = 5;
    localparam int WORD_BITS  = 32;
    localparam int ALU_BITS   = 6;
    localparam int SHAMT_BITS = 5;

    // LSB position of each issue queue entry field
    localparam int IQ_MEM_READ_BIT  = 0;
    localparam int IQ_MEM_WRITE_BIT = IQ_MEM_READ_BIT + 1;
    localparam int IQ_DEST_LSB      = IQ_MEM_WRITE_BIT + 1;
    localparam int IQ_WRITES_BIT    = IQ_DEST_LSB + LOG_PHYS;
    localparam int IQ_SHAMT_LSB     = IQ_WRITES_BIT + 1;
    localparam int IQ_SRC_B_RDY_BIT = IQ_SHAMT_LSB + SHAMT_BITS;
    localparam int IQ_SRC_B_LSB     = IQ_SRC_B_RDY_BIT + 1;
    localparam int IQ_SRC_A_RDY_BIT = IQ_SRC_B_LSB + LOG_PHYS;
    localparam int IQ_SRC_A_LSB     = IQ_SRC_A_RDY_BIT + 1;
    localparam int IQ_IMM_LSB       = IQ_SRC_A_LSB + LOG_PHYS;
    localparam int IQ_HAS_IMM_BIT   = IQ_IMM_LSB + WORD_BITS;
    localparam int IQ_ALU_LSB       = IQ_HAS_IMM_BIT + 1;
    localparam int IQ_ENTRY_BITS    = IQ_ALU_LSB + ALU_BITS;

    // load/store queue entry
    localparam int LSQ_PHYS_LSB   = 0;                       // load dest or store base
    localparam int LSQ_STORE_BIT  = LSQ_PHYS_LSB + LOG_PHYS;
    localparam int LSQ_ENTRY_BITS = LSQ_STORE_BIT + 1;

    // reorder buffer entry
    localparam int ROB_SPARE_BIT   = 0;
    localparam int ROB_ARCH_LSB    = ROB_SPARE_BIT + 1;
    localparam int ROB_OLD_LSB     = ROB_ARCH_LSB + LOG_ARCH;   // mapping freed at commit
    localparam int ROB_DEST_LSB    = ROB_OLD_LSB + LOG_PHYS;
    localparam int ROB_WRITES_BIT  = ROB_DEST_LSB + LOG_PHYS;
    localparam int ROB_ALT_REQ_BIT = ROB_WRITES_BIT + 1;
    localparam int ROB_ALT_PC_LSB  = ROB_ALT_REQ_BIT + 1;
    localparam int ROB_ADDR_LSB    = ROB_ALT_PC_LSB + WORD_BITS;
    localparam int ROB_INSTR_LSB   = ROB_ADDR_LSB + WORD_BITS;
    localparam int ROB_ENTRY_BITS  = ROB_INSTR_LSB + WORD_BITS;

endpackage

`default_nettype wire

// File: verilog/rat_if.sv
`timescale 1ns/10ps
`default_nettype none

interface rat_if (
    input logic CLK
);

    // lookups driven by the rename stage
    logic [rename_pkg::LOG_ARCH-1:0] src_a_arch;
    logic [rename_pkg::LOG_ARCH-1:0] src_b_arch;
    logic [rename_pkg::LOG_ARCH-1:0] dest_arch;

    // map update
    logic                            map_write;    // accepted instr allocates
    logic [rename_pkg::LOG_PHYS-1:0] map_phys;     // new mapping for dest_arch

    // answers from the alias table
    logic [rename_pkg::LOG_PHYS-1:0] src_a_phys;
    logic [rename_pkg::LOG_PHYS-1:0] src_b_phys;
    logic                            src_a_busy;
    logic                            src_b_busy;
    logic [rename_pkg::LOG_PHYS-1:0] old_phys;     // prior mapping of dest_arch

    modport stage (
        output src_a_arch, src_b_arch, dest_arch, map_write, map_phys,
        input  src_a_phys, src_b_phys, src_a_busy, src_b_busy, old_phys
    );

    modport map_table (
        input  src_a_arch, src_b_arch, dest_arch, map_write, map_phys,
        output src_a_phys, src_b_phys, src_a_busy, src_b_busy, old_phys
    );

    // phys 0 backs r0 and is never on the free list
    a_map_phys_nonzero: assert property (
        @(posedge CLK) map_write |-> map_phys != '0
    );

endinterface

`default_nettype wire

// File: verilog/front_rat.sv
`timescale 1ns/10ps
`default_nettype none

module front_rat (
    input  logic                            CLK,
    input  logic                            RESET,
    rat_if.map_table                        rat,
    input  logic                            wb_valid,
    input  logic [rename_pkg::LOG_PHYS-1:0] wb_phys
);

    logic [rename_pkg::LOG_PHYS-1:0] map_q [rename_pkg::NUM_ARCH];
    logic [rename_pkg::NUM_PHYS-1:0] busy_q;   // one bit per physical register

    logic [rename_pkg::LOG_PHYS-1:0] map_a;
    logic [rename_pkg::LOG_PHYS-1:0] map_b;

    // map table starts as the identity
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < rename_pkg::NUM_ARCH; i++) begin
                map_q[i] <= rename_pkg::LOG_PHYS'(i);
            end
        end else if (rat.map_write) begin
            map_q[rat.dest_arch] <= rat.map_phys;
        end
    end

    // busy bits
    // the rename set wins over a writeback clear of the same register
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            busy_q <= '0;
        end else begin
            if (wb_valid) begin
                busy_q[wb_phys] <= 1'b0;           // result written back
            end
            if (rat.map_write) begin
                busy_q[rat.map_phys] <= 1'b1;      // new producer in flight
            end
        end
    end

    assign map_a = map_q[rat.src_a_arch];
    assign map_b = map_q[rat.src_b_arch];

    // r0 always reads phys 0 and is never busy
    always_comb begin
        rat.src_a_phys = '0;
        rat.src_a_busy = 1'b0;
        rat.src_b_phys = '0;
        rat.src_b_busy = 1'b0;
        if (rat.src_a_arch != '0) begin
            rat.src_a_phys = map_a;
            rat.src_a_busy = busy_q[map_a];
        end
        if (rat.src_b_arch != '0) begin
            rat.src_b_phys = map_b;
            rat.src_b_busy = busy_q[map_b];
        end
    end

    assign rat.old_phys = map_q[rat.dest_arch];

    // the stage must never remap r0
    a_no_r0_write: assert property (
        @(posedge CLK) disable iff (!RESET)
        rat.map_write |-> rat.dest_arch != '0
    );

endmodule

`default_nettype wire

// File: verilog/free_list.sv
`timescale 1ns/10ps
`default_nettype none

module free_list (
    input  logic                            CLK,
    input  logic                            RESET,
    input  logic                            grab,           // pop head at this edge
    output logic [rename_pkg::LOG_PHYS-1:0] free_head,
    output logic                            free_avail,
    input  logic                            release_valid,  // commit frees a register
    input  logic [rename_pkg::LOG_PHYS-1:0] release_phys
);

    logic [rename_pkg::LOG_PHYS-1:0] fifo_q [rename_pkg::FREE_DEPTH];
    logic [rename_pkg::LOG_FREE-1:0] head_q;
    logic [rename_pkg::LOG_FREE-1:0] tail_q;
    logic [rename_pkg::LOG_FREE:0]   count_q;   // 0 to FREE_DEPTH

    // storage starts out full with the registers above the arch range
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < rename_pkg::FREE_DEPTH; i++) begin
                fifo_q[i] <= rename_pkg::LOG_PHYS'(rename_pkg::NUM_ARCH + i);
            end
        end else if (release_valid) begin
            fifo_q[tail_q] <= release_phys;
        end
    end

    // pointers wrap naturally at the power-of-two depth
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            if (grab) begin
                head_q <= head_q + 1'b1;
            end
            if (release_valid) begin
                tail_q <= tail_q + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            count_q <= (rename_pkg::LOG_FREE + 1)'(rename_pkg::FREE_DEPTH);
        end else begin
            case ({release_valid, grab})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;          // none, or one in and one out
            endcase
        end
    end

    assign free_avail = (count_q != '0);
    assign free_head  = fifo_q[head_q];

    a_no_grab_empty: assert property (
        @(posedge CLK) disable iff (!RESET)
        grab |-> count_q != '0
    );

    // a release into a full list would overwrite the head
    a_no_release_full: assert property (
        @(posedge CLK) disable iff (!RESET)
        release_valid |-> count_q != (rename_pkg::LOG_FREE + 1)'(rename_pkg::FREE_DEPTH)
    );

endmodule

`default_nettype wire

// File: verilog/rename_stage.sv
`timescale 1ns/10ps
`default_nettype none

module rename_stage (
    input  logic                                  CLK,
    input  logic                                  RESET,

    // decoded instruction at the head of the decode FIFO
    input  logic                                  instr_valid,
    input  logic [31:0]                           instr,
    input  logic [31:0]                           instr_addr,
    input  logic [31:0]                           alt_pc,
    input  logic                                  alt_req,
    input  logic                                  has_imm,
    input  logic [31:0]                           imm,
    input  logic [rename_pkg::LOG_ARCH-1:0]       src_a,
    input  logic [rename_pkg::LOG_ARCH-1:0]       src_b,
    input  logic [rename_pkg::LOG_ARCH-1:0]       dest,
    input  logic                                  reg_write,
    input  logic                                  mem_read,
    input  logic                                  mem_write,
    input  logic [rename_pkg::ALU_BITS-1:0]       alu_ctrl,
    input  logic [rename_pkg::SHAMT_BITS-1:0]     shamt,

    input  logic                                  rob_full,
    input  logic                                  iq_full,
    input  logic                                  lsq_full,

    rat_if.stage                                  rat,

    input  logic                                  free_avail,
    input  logic [rename_pkg::LOG_PHYS-1:0]       free_head,
    output logic                                  grab,

    output logic                                  pop,
    output logic                                  blocked,
    output logic [rename_pkg::IQ_ENTRY_BITS-1:0]  iq_entry,
    output logic                                  iq_valid,
    output logic [rename_pkg::LSQ_ENTRY_BITS-1:0] lsq_entry,
    output logic                                  lsq_valid,
    output logic [rename_pkg::ROB_ENTRY_BITS-1:0] rob_entry,
    output logic                                  rob_valid
);

    logic                                  alloc;
    logic                                  is_mem;
    logic                                  stall;
    logic                                  accept;
    logic                                  src_a_ready;
    logic                                  src_b_ready;
    logic [rename_pkg::LOG_PHYS-1:0]       dest_phys;
    logic [rename_pkg::LOG_PHYS-1:0]       old_phys;
    logic [rename_pkg::IQ_ENTRY_BITS-1:0]  iq_next;
    logic [rename_pkg::LSQ_ENTRY_BITS-1:0] lsq_next;
    logic [rename_pkg::ROB_ENTRY_BITS-1:0] rob_next;

    assign alloc  = reg_write && (dest != '0);   // r0 writes get no register
    assign is_mem = mem_read || mem_write;

    assign stall  = rob_full || iq_full || (is_mem && lsq_full) || (alloc && !free_avail);
    assign accept = instr_valid && !stall;

    assign pop     = accept;
    assign blocked = !instr_valid || stall;
    assign grab    = accept && alloc;

    assign rat.src_a_arch = src_a;
    assign rat.src_b_arch = src_b;
    assign rat.dest_arch  = dest;
    assign rat.map_write  = grab;
    assign rat.map_phys   = free_head;

    // r0 already comes back not busy from the table
    assign src_a_ready = has_imm || !rat.src_a_busy;
    assign src_b_ready = has_imm || !rat.src_b_busy;

    assign dest_phys = alloc ? free_head : '0;
    assign old_phys  = alloc ? rat.old_phys : '0;

    always_comb begin
        iq_next = '0;
        iq_next[rename_pkg::IQ_ALU_LSB +: rename_pkg::ALU_BITS]     = alu_ctrl;
        iq_next[rename_pkg::IQ_HAS_IMM_BIT]                         = has_imm;
        iq_next[rename_pkg::IQ_IMM_LSB +: rename_pkg::WORD_BITS]    = imm;
        iq_next[rename_pkg::IQ_SRC_A_LSB +: rename_pkg::LOG_PHYS]   = rat.src_a_phys;
        iq_next[rename_pkg::IQ_SRC_A_RDY_BIT]                       = src_a_ready;
        iq_next[rename_pkg::IQ_SRC_B_LSB +: rename_pkg::LOG_PHYS]   = rat.src_b_phys;
        iq_next[rename_pkg::IQ_SRC_B_RDY_BIT]                       = src_b_ready;
        iq_next[rename_pkg::IQ_SHAMT_LSB +: rename_pkg::SHAMT_BITS] = shamt;
        iq_next[rename_pkg::IQ_WRITES_BIT]                          = alloc;
        iq_next[rename_pkg::IQ_DEST_LSB +: rename_pkg::LOG_PHYS]    = dest_phys;
        iq_next[rename_pkg::IQ_MEM_WRITE_BIT]                       = mem_write;
        iq_next[rename_pkg::IQ_MEM_READ_BIT]                        = mem_read;
    end

    // stores carry the base address register, loads their destination
    always_comb begin
        lsq_next = '0;
        lsq_next[rename_pkg::LSQ_STORE_BIT] = mem_write;
        lsq_next[rename_pkg::LSQ_PHYS_LSB +: rename_pkg::LOG_PHYS] =
            mem_write ? rat.src_a_phys : dest_phys;
    end

    always_comb begin
        rob_next = '0;
        rob_next[rename_pkg::ROB_INSTR_LSB +: rename_pkg::WORD_BITS]  = instr;
        rob_next[rename_pkg::ROB_ADDR_LSB +: rename_pkg::WORD_BITS]   = instr_addr;
        rob_next[rename_pkg::ROB_ALT_PC_LSB +: rename_pkg::WORD_BITS] = alt_pc;
        rob_next[rename_pkg::ROB_ALT_REQ_BIT]                         = alt_req;
        rob_next[rename_pkg::ROB_WRITES_BIT]                          = alloc;
        rob_next[rename_pkg::ROB_DEST_LSB +: rename_pkg::LOG_PHYS]    = dest_phys;
        rob_next[rename_pkg::ROB_OLD_LSB +: rename_pkg::LOG_PHYS]     = old_phys;
        rob_next[rename_pkg::ROB_ARCH_LSB +: rename_pkg::LOG_ARCH]    = dest;
        rob_next[rename_pkg::ROB_SPARE_BIT]                           = 1'b0;
    end

    // valids pulse for one cycle after each accept
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            iq_valid  <= 1'b0;
            lsq_valid <= 1'b0;
            rob_valid <= 1'b0;
        end else begin
            iq_valid  <= accept;
            lsq_valid <= accept && is_mem;
            rob_valid <= accept;
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            iq_entry  <= iq_next;
            rob_entry <= rob_next;
        end
        if (accept && is_mem) begin
            lsq_entry <= lsq_next;
        end
    end

    a_grab_avail: assert property (
        @(posedge CLK) disable iff (!RESET)
        grab |-> free_avail
    );

endmodule

`default_nettype wire

// File: verilog/rename_top.sv
`timescale 1ns/10ps
`default_nettype none

module rename_top (
    input  logic                                  CLK,
    input  logic                                  RESET,
    input  logic                                  instr_valid,
    input  logic [31:0]                           instr,
    input  logic [31:0]                           instr_addr,
    input  logic [31:0]                           alt_pc,
    input  logic                                  alt_req,
    input  logic                                  has_imm,
    input  logic [31:0]                           imm,
    input  logic [rename_pkg::LOG_ARCH-1:0]       src_a,
    input  logic [rename_pkg::LOG_ARCH-1:0]       src_b,
    input  logic [rename_pkg::LOG_ARCH-1:0]       dest,
    input  logic                                  reg_write,
    input  logic                                  mem_read,
    input  logic                                  mem_write,
    input  logic [rename_pkg::ALU_BITS-1:0]       alu_ctrl,
    input  logic [rename_pkg::SHAMT_BITS-1:0]     shamt,
    input  logic                                  rob_full,
    input  logic                                  iq_full,
    input  logic                                  lsq_full,
    input  logic                                  wb_valid,        // writeback clears busy
    input  logic [rename_pkg::LOG_PHYS-1:0]       wb_phys,
    input  logic                                  release_valid,   // commit frees old phys
    input  logic [rename_pkg::LOG_PHYS-1:0]       release_phys,
    output logic                                  pop,
    output logic                                  blocked,
    output logic [rename_pkg::IQ_ENTRY_BITS-1:0]  iq_entry,
    output logic                                  iq_valid,
    output logic [rename_pkg::LSQ_ENTRY_BITS-1:0] lsq_entry,
    output logic                                  lsq_valid,
    output logic [rename_pkg::ROB_ENTRY_BITS-1:0] rob_entry,
    output logic                                  rob_valid
);

    logic                            grab;
    logic                            free_avail;
    logic [rename_pkg::LOG_PHYS-1:0] free_head;

    rat_if rat (.CLK(CLK));

    front_rat u_rat (
        .CLK(CLK), .RESET(RESET), .rat(rat.map_table),
        .wb_valid(wb_valid), .wb_phys(wb_phys)
    );

    free_list u_free (
        .CLK(CLK), .RESET(RESET), .grab(grab),
        .free_head(free_head), .free_avail(free_avail),
        .release_valid(release_valid), .release_phys(release_phys)
    );

    rename_stage u_stage (
        .CLK(CLK), .RESET(RESET), .instr_valid(instr_valid),
        .instr(instr), .instr_addr(instr_addr), .alt_pc(alt_pc), .alt_req(alt_req),
        .has_imm(has_imm), .imm(imm), .src_a(src_a), .src_b(src_b), .dest(dest),
        .reg_write(reg_write), .mem_read(mem_read), .mem_write(mem_write),
        .alu_ctrl(alu_ctrl), .shamt(shamt),
        .rob_full(rob_full), .iq_full(iq_full), .lsq_full(lsq_full),
        .rat(rat.stage), .free_avail(free_avail), .free_head(free_head), .grab(grab),
        .pop(pop), .blocked(blocked),
        .iq_entry(iq_entry), .iq_valid(iq_valid),
        .lsq_entry(lsq_entry), .lsq_valid(lsq_valid),
        .rob_entry(rob_entry), .rob_valid(rob_valid)
    );

endmodule

`default_nettype wire

// File: dv/tb_rename_checks.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rename_checks (
    input  logic                                  CLK,
    input  logic                                  RESET,
    input  logic                                  pop,
    input  logic                                  blocked,
    input  logic [rename_pkg::IQ_ENTRY_BITS-1:0]  iq_entry,
    input  logic                                  iq_valid,
    input  logic [rename_pkg::LSQ_ENTRY_BITS-1:0] lsq_entry,
    input  logic                                  lsq_valid,
    input  logic [rename_pkg::ROB_ENTRY_BITS-1:0] rob_entry,
    input  logic                                  rob_valid,
    input  logic                                  exp_pop,
    input  logic                                  exp_blocked,
    input  logic                                  exp_mem,
    input  logic [rename_pkg::IQ_ENTRY_BITS-1:0]  exp_iq,
    input  logic [rename_pkg::LSQ_ENTRY_BITS-1:0] exp_lsq,
    input  logic [rename_pkg::ROB_ENTRY_BITS-1:0] exp_rob,
    output int                                    errors
);

    logic                                  pop_q;    // accept seen at the last edge
    logic                                  mem_q;
    logic [rename_pkg::IQ_ENTRY_BITS-1:0]  iq_q;
    logic [rename_pkg::LSQ_ENTRY_BITS-1:0] lsq_q;
    logic [rename_pkg::ROB_ENTRY_BITS-1:0] rob_q;

    initial errors = 0;

    always_ff @(posedge CLK) begin
        pop_q <= exp_pop;
        mem_q <= exp_pop && exp_mem;
        iq_q  <= exp_iq;
        lsq_q <= exp_lsq;
        rob_q <= exp_rob;
    end

    a_pop: assert property (@(posedge CLK) disable iff (!RESET) pop == exp_pop)
        else begin
            errors++;
            $display("Error pop expected %h actual %h", $sampled(exp_pop), $sampled(pop));
        end

    a_blocked: assert property (@(posedge CLK) disable iff (!RESET) blocked == exp_blocked)
        else begin
            errors++;
            $display("Error blocked expected %h actual %h",
                     $sampled(exp_blocked), $sampled(blocked));
        end

    // entries are compared only while their valid is up
    a_iq: assert property (@(posedge CLK) disable iff (!RESET)
        iq_valid == pop_q && (!pop_q || iq_entry == iq_q))
        else begin
            errors++;
            $display("Error iq_valid/iq_entry expected %h/%h actual %h/%h",
                     $sampled(pop_q), $sampled(iq_q), $sampled(iq_valid), $sampled(iq_entry));
        end

    a_lsq: assert property (@(posedge CLK) disable iff (!RESET)
        lsq_valid == mem_q && (!mem_q || lsq_entry == lsq_q))
        else begin
            errors++;
            $display("Error lsq_valid/lsq_entry expected %h/%h actual %h/%h",
                     $sampled(mem_q), $sampled(lsq_q), $sampled(lsq_valid),
                     $sampled(lsq_entry));
        end

    a_rob: assert property (@(posedge CLK) disable iff (!RESET)
        rob_valid == pop_q && (!pop_q || rob_entry == rob_q))
        else begin
            errors++;
            $display("Error rob_valid/rob_entry expected %h/%h actual %h/%h",
                     $sampled(pop_q), $sampled(rob_q), $sampled(rob_valid),
                     $sampled(rob_entry));
        end

endmodule

`default_nettype wire

// File: dv/tb_rename.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rename;

    logic                                  CLK;
    logic                                  RESET;
    logic                                  instr_valid;
    logic [31:0]                           instr;
    logic [31:0]                           instr_addr;
    logic [31:0]                           alt_pc;
    logic [31:0]                           imm;
    logic                                  alt_req;
    logic                                  has_imm;
    logic [4:0]                            src_a;
    logic [4:0]                            src_b;
    logic [4:0]                            dest;
    logic                                  reg_write;
    logic                                  mem_read;
    logic                                  mem_write;
    logic [5:0]                            alu_ctrl;
    logic [4:0]                            shamt;
    logic                                  rob_full, iq_full, lsq_full;
    logic                                  wb_valid, release_valid;
    logic [5:0]                            wb_phys, release_phys;
    logic                                  pop, blocked, iq_valid, lsq_valid, rob_valid;
    logic [rename_pkg::IQ_ENTRY_BITS-1:0]  iq_entry, exp_iq;
    logic [rename_pkg::LSQ_ENTRY_BITS-1:0] lsq_entry, exp_lsq;
    logic [rename_pkg::ROB_ENTRY_BITS-1:0] rob_entry, exp_rob;
    logic                                  exp_pop, exp_blocked, exp_mem;

    logic [5:0] map_m [32];
    logic       busy_m [64];
    logic [5:0] free_m [$];
    logic [5:0] old_m [$];        // previous mappings in commit order
    logic [5:0] inflight_m [$];   // allocated and not yet written back
    logic       rand_mode;
    int         timeouts;
    int         assert_errors;

    rename_top UUT (.*);

    tb_rename_checks u_checks (.*, .errors(assert_errors));

    initial CLK = 1'b0;
    always #20 CLK = ~CLK;

    // expected words use the state before the edge, then the model steps
    task automatic predict();
        logic       alloc;
        logic       stall;
        logic       ra;
        logic       rb;
        logic [5:0] pa;
        logic [5:0] pb;
        logic [5:0] dphys;
        logic [5:0] ophys;
        int         hit [$];
        alloc = reg_write && dest != 5'd0;
        exp_mem = mem_read || mem_write;
        stall = rob_full || iq_full || (exp_mem && lsq_full) || (alloc && free_m.size() == 0);
        exp_pop = instr_valid && !stall;
        exp_blocked = !instr_valid || stall;
        pa = (src_a == 5'd0) ? 6'd0 : map_m[src_a];
        pb = (src_b == 5'd0) ? 6'd0 : map_m[src_b];
        ra = has_imm || src_a == 5'd0 || !busy_m[pa];
        rb = has_imm || src_b == 5'd0 || !busy_m[pb];
        dphys = (alloc && free_m.size() > 0) ? free_m[0] : 6'd0;
        ophys = alloc ? map_m[dest] : 6'd0;
        exp_iq = {alu_ctrl, has_imm, imm, pa, ra, pb, rb, shamt, alloc, dphys, mem_write, mem_read};
        exp_lsq = {mem_write, mem_write ? pa : dphys};
        exp_rob = {instr, instr_addr, alt_pc, alt_req, alloc, dphys, ophys, dest, 1'b0};
        if (wb_valid) begin
            busy_m[wb_phys] = 1'b0;
            hit = inflight_m.find_first_index(x) with (x == wb_phys);
            if (hit.size() > 0)
                inflight_m.delete(hit[0]);
        end
        if (exp_pop && alloc) begin
            void'(free_m.pop_front());
            map_m[dest] = dphys;
            busy_m[dphys] = 1'b1;
            inflight_m.push_back(dphys);
            old_m.push_back(ophys);
        end
        if (release_valid)
            free_m.push_back(release_phys);
    endtask

    task automatic drive_random_side();
        int k;
        rob_full = ($urandom % 6) == 0;
        iq_full  = ($urandom % 6) == 0;
        lsq_full = ($urandom % 4) == 0;
        if (inflight_m.size() > 0 && ($urandom % 2) == 0) begin
            k = $urandom % inflight_m.size();
            wb_valid = 1'b1;
            wb_phys  = inflight_m[k];
        end
        if (old_m.size() > 0 && !busy_m[old_m[0]] && ($urandom % 2) == 0) begin
            release_valid = 1'b1;               // only dead, written-back mappings
            release_phys  = old_m.pop_front();
        end
    endtask

    task automatic run_cycle(output logic took);
        if (rand_mode)
            drive_random_side();
        predict();
        #10;                                    // pop has settled by mid low phase
        took = pop;
        @(negedge CLK);
        wb_valid = 1'b0;
        release_valid = 1'b0;
    endtask

    task automatic run_cycles(input int n);
        logic took;
        repeat (n) run_cycle(took);
    endtask

    task automatic wait_accept(input string what);
        logic took;
        int   n;
        took = 1'b0;
        n = 0;
        instr_valid = 1'b1;
        while (!took && n < 200) begin
            run_cycle(took);
            n++;
        end
        instr_valid = 1'b0;
        if (!took) begin
            timeouts++;
            $display("timeout: %s was never accepted", what);
        end
    endtask

    task automatic set_instr(input logic [4:0] sa, input logic [4:0] sb, input logic [4:0] d,
                             input logic rw, input logic mr, input logic mw, input logic hi);
        src_a = sa;
        src_b = sb;
        dest = d;
        reg_write = rw;
        mem_read = mr;
        mem_write = mw;
        has_imm = hi;
        instr = $urandom;
        instr_addr = $urandom;
        alt_pc = $urandom;
        alt_req = 1'($urandom);
        imm = $urandom;
        alu_ctrl = 6'($urandom);
        shamt = 5'($urandom);
    endtask

    initial begin
        logic [5:0] p;
        int         guard;
        int         kind;
        void'($urandom(32'h63b5_de2a));
        RESET = 1'b0;
        instr_valid = 1'b0;
        {rob_full, iq_full, lsq_full, wb_valid, release_valid} = '0;
        wb_phys = '0;
        release_phys = '0;
        {rand_mode, exp_pop, exp_mem, exp_blocked} = 4'b0001;
        {exp_iq, exp_lsq, exp_rob} = '0;
        timeouts = 0;
        set_instr(5'd0, 5'd0, 5'd0, 1'b0, 1'b0, 1'b0, 1'b0);
        for (int i = 0; i < 64; i++) begin
            busy_m[i] = 1'b0;
        end
        for (int i = 0; i < 32; i++) begin
            map_m[i] = 6'(i);
            free_m.push_back(6'(32 + i));
        end
        repeat (2) @(negedge CLK);
        RESET = 1'b1;

        set_instr(5'd1, 5'd2, 5'd3, 1'b1, 1'b0, 1'b0, 1'b0);
        wait_accept("first ALU writer");
        p = free_m[0];
        set_instr(5'd1, 5'd2, 5'd4, 1'b1, 1'b0, 1'b0, 1'b0);
        wait_accept("chain producer");
        set_instr(5'd4, 5'd3, 5'd5, 1'b1, 1'b0, 1'b0, 1'b0);   // r4 not ready yet
        wait_accept("chain consumer");
        wb_valid = 1'b1;
        wb_phys = p;
        run_cycles(1);
        set_instr(5'd4, 5'd4, 5'd6, 1'b1, 1'b0, 1'b0, 1'b0);
        wait_accept("consumer after writeback");

        set_instr(5'd2, 5'd0, 5'd7, 1'b1, 1'b1, 1'b0, 1'b1);
        wait_accept("load");
        set_instr(5'd7, 5'd3, 5'd0, 1'b0, 1'b0, 1'b1, 1'b1);
        wait_accept("store");
        set_instr(5'd7, 5'd1, 5'd8, 1'b1, 1'b0, 1'b0, 1'b0);
        wait_accept("writer after store");

        // back-pressure from each full flag in turn
        rob_full = 1'b1;
        set_instr(5'd1, 5'd2, 5'd9, 1'b1, 1'b0, 1'b0, 1'b0);
        instr_valid = 1'b1;
        run_cycles(3);
        rob_full = 1'b0;
        wait_accept("writer after rob_full");
        iq_full = 1'b1;
        set_instr(5'd9, 5'd2, 5'd10, 1'b1, 1'b0, 1'b0, 1'b0);
        instr_valid = 1'b1;
        run_cycles(3);
        iq_full = 1'b0;
        wait_accept("writer after iq_full");
        lsq_full = 1'b1;
        set_instr(5'd1, 5'd0, 5'd11, 1'b1, 1'b1, 1'b0, 1'b1);
        instr_valid = 1'b1;
        run_cycles(3);
        lsq_full = 1'b0;
        wait_accept("load after lsq_full");
        lsq_full = 1'b1;
        set_instr(5'd1, 5'd2, 5'd12, 1'b1, 1'b0, 1'b0, 1'b0);
        wait_accept("ALU op under lsq_full");
        lsq_full = 1'b0;

        // drain the free list, then unblock with one release
        guard = 0;
        while (free_m.size() > 0 && guard < 64) begin
            set_instr(5'd1, 5'd2, 5'(1 + guard % 31), 1'b1, 1'b0, 1'b0, 1'b0);
            wait_accept("writer draining the free list");
            guard++;
        end
        set_instr(5'd1, 5'd2, 5'd13, 1'b1, 1'b0, 1'b0, 1'b0);
        instr_valid = 1'b1;
        run_cycles(3);
        release_valid = 1'b1;
        release_phys = old_m.pop_front();
        wait_accept("writer after release");

        rand_mode = 1'b1;
        for (int i = 0; i < 300; i++) begin
            kind = $urandom % 4;                 // 0 and 2 ALU, 1 load, 3 store
            set_instr(5'($urandom), 5'($urandom), 5'($urandom), kind != 3, kind == 1,
                      kind == 3, 1'($urandom));
            wait_accept("random instruction");
        end
        rand_mode = 1'b0;
        {rob_full, iq_full, lsq_full} = '0;
        run_cycles(3);

        $display("errors: %0d assertion, %0d timeout", assert_errors, timeouts);
        if (assert_errors == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
verilog/rename_pkg.sv
verilog/rat_if.sv
verilog/front_rat.sv
verilog/free_list.sv
verilog/rename_stage.sv
verilog/rename_top.sv
dv/tb_rename_checks.sv
dv/tb_rename.sv
